// File: source/ccm_pkg.sv
// ------------------------------
// colour correction matrix shared definitions
// coefficient format, register map and bus word types
// ------------------------------
package ccm_pkg;

    // ------------------------------
    // coefficient format
    // ------------------------------

    // signed Q5.10, 0x0400 is 1.0
    localparam int COE_WIDTH = 16;
    localparam int COE_FRAC  = 10;
    // 3x3 matrix, row major
    localparam int COE_COUNT = 9;

    typedef logic [COE_WIDTH-1:0] coe_t;

    localparam coe_t COE_ONE = 16'h0400;

    // ------------------------------
    // register bus
    // ------------------------------

    typedef logic [3:0]  wb_adr_t;
    typedef logic [15:0] wb_dat_t;

    // addresses 0..8 hold the coefficients
    // row 0 -> red, columns r, g, b
    localparam wb_adr_t REG_CTRL_ADR = 4'd9;

    // matrix applied when set, bypass otherwise
    localparam int CTRL_EN_BIT = 0;

endpackage

// File: source/ccm_wb_regs.sv
`timescale 1ns/1ps
// ------------------------------
// ccm register bank on a Wishbone classic slave
// staging coefficients and enable, copied to the
// active set at each rising edge of vertical sync
// ------------------------------
module ccm_wb_regs (
    input  logic                                            clk,
    input  logic                                            rst_n_i,
    // Wishbone classic slave
    input  logic                                            wb_cyc_i,
    input  logic                                            wb_stb_i,
    input  logic                                            wb_we_i,
    input  ccm_pkg::wb_adr_t                                wb_adr_i,
    input  ccm_pkg::wb_dat_t                                wb_dat_i,
    output ccm_pkg::wb_dat_t                                wb_dat_o,
    output logic                                            wb_ack_o,
    // frame sync
    input  logic                                            vs_i,
    // active set towards the matrix
    output logic [ccm_pkg::COE_COUNT*ccm_pkg::COE_WIDTH-1:0] coe_o,
    output logic                                            en_o
);
    import ccm_pkg::*;

    coe_t    coe_stg [COE_COUNT];
    coe_t    coe_act [COE_COUNT];
    logic    en_stg;
    logic    en_act;
    logic    vs_d;
    logic    req;
    logic    adr_coe;
    logic    frame_start;
    wb_dat_t rd_data;

    // identity matrix: diagonal at 1.0, rest zero
    function automatic coe_t identity_coe(input int idx);
        return ((idx / 3) == (idx % 3)) ? COE_ONE : coe_t'(0);
    endfunction

    // ------------------------------
    // bus decode
    // ------------------------------

    // a new request, the ack cycle itself is not counted again
    assign req     = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign adr_coe = (wb_adr_i < wb_adr_t'(COE_COUNT));

    // single-cycle ack, always low for a cycle in between
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= req;
        end
    end

    // read back of the staging values, unmapped words read 0
    always_comb begin
        rd_data = '0;
        if (adr_coe) begin
            rd_data = wb_dat_t'(coe_stg[wb_adr_i]);
        end else if (wb_adr_i == REG_CTRL_ADR) begin
            rd_data[CTRL_EN_BIT] = en_stg;
        end
    end

    // valid together with the ack
    always_ff @(posedge clk) begin
        if (req && !wb_we_i) begin
            wb_dat_o <= rd_data;
        end
    end

    // staging registers
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < COE_COUNT; k++) begin
                coe_stg[k] <= identity_coe(k);
            end
            en_stg <= 1'b0;
        end else if (req && wb_we_i) begin
            if (adr_coe) begin
                coe_stg[wb_adr_i] <= coe_t'(wb_dat_i);
            end else if (wb_adr_i == REG_CTRL_ADR) begin
                en_stg <= wb_dat_i[CTRL_EN_BIT];
            end
        end
    end

    // ------------------------------
    // frame-synchronous update
    // ------------------------------

    assign frame_start = vs_i & ~vs_d;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vs_d <= 1'b0;
            for (int k = 0; k < COE_COUNT; k++) begin
                coe_act[k] <= identity_coe(k);
            end
            en_act <= 1'b0;
        end else begin
            vs_d <= vs_i;
            // whole matrix swapped at once, never mid-frame
            if (frame_start) begin
                coe_act <= coe_stg;
                en_act  <= en_stg;
            end
        end
    end

    // flatten, entry k in slice k
    always_comb begin
        for (int k = 0; k < COE_COUNT; k++) begin
            coe_o[k*COE_WIDTH +: COE_WIDTH] = coe_act[k];
        end
    end

    assign en_o = en_act;

endmodule

// File: source/ccm_channel_mac.sv
`timescale 1ns/1ps
// ------------------------------
// ccm channel multiply-accumulate
// one output colour: three products, sum, round, clamp
// ------------------------------
module ccm_channel_mac #(
    parameter int PIXEL_WIDTH = 8
) (
    input  logic                     clk,
    input  ccm_pkg::coe_t            coe_r_i,
    input  ccm_pkg::coe_t            coe_g_i,
    input  ccm_pkg::coe_t            coe_b_i,
    // red low, then green, then blue
    input  logic [3*PIXEL_WIDTH-1:0] pix_i,
    output logic [PIXEL_WIDTH-1:0]   chan_o
);
    import ccm_pkg::*;

    // product of a signed coefficient and a zero-extended component
    localparam int PROD_W  = COE_WIDTH + PIXEL_WIDTH + 1;
    localparam int PART_W  = PROD_W + 1;
    localparam int SUM_W   = PROD_W + 2;
    localparam int RND_W   = SUM_W + 1;
    // first bit at or above full scale
    localparam int OVF_BIT = PIXEL_WIDTH + COE_FRAC;

    typedef logic signed [PROD_W-1:0] prod_t;
    typedef logic signed [PART_W-1:0] part_t;
    typedef logic signed [SUM_W-1:0]  sum_t;
    typedef logic signed [RND_W-1:0]  rnd_t;

    // 0.5 in output LSBs
    localparam rnd_t HALF_LSB = rnd_t'(2 ** (COE_FRAC - 1));

    logic [PIXEL_WIDTH-1:0] pix_r;
    logic [PIXEL_WIDTH-1:0] pix_g;
    logic [PIXEL_WIDTH-1:0] pix_b;

    prod_t mul_r;
    prod_t mul_g;
    prod_t mul_b;
    prod_t mul_b_d;
    part_t part_rg;
    sum_t  sum_rgb;
    rnd_t  sum_rnd;

    assign pix_r = pix_i[0*PIXEL_WIDTH +: PIXEL_WIDTH];
    assign pix_g = pix_i[1*PIXEL_WIDTH +: PIXEL_WIDTH];
    assign pix_b = pix_i[2*PIXEL_WIDTH +: PIXEL_WIDTH];

    // ------------------------------
    // arithmetic pipeline
    // ------------------------------

    always_ff @(posedge clk) begin
        // stage 1: multiply, components taken as unsigned
        mul_r <= $signed(coe_r_i) * $signed({1'b0, pix_r});
        mul_g <= $signed(coe_g_i) * $signed({1'b0, pix_g});
        mul_b <= $signed(coe_b_i) * $signed({1'b0, pix_b});

        // stage 2: partial sum, blue product waits a cycle
        part_rg <= part_t'(mul_r) + part_t'(mul_g);
        mul_b_d <= mul_b;

        // stage 3: full sum
        sum_rgb <= sum_t'(part_rg) + sum_t'(mul_b_d);

        // stage 4: round half up
        sum_rnd <= rnd_t'(sum_rgb) + HALF_LSB;
    end

    // stage 5: clamp to the pixel range
    always_ff @(posedge clk) begin
        if (sum_rnd[RND_W-1]) begin
            // negative result
            chan_o <= '0;
        end else if (|sum_rnd[RND_W-2:OVF_BIT]) begin
            chan_o <= '1;
        end else begin
            chan_o <= sum_rnd[COE_FRAC +: PIXEL_WIDTH];
        end
    end

endmodule

// File: source/ccm_matrix.sv
`timescale 1ns/1ps
// ------------------------------
// ccm 3x3 matrix datapath
// three channel units plus matched sync and bypass delay
// ------------------------------
module ccm_matrix #(
    parameter int PIXEL_WIDTH = 8
) (
    input  logic                                             clk,
    input  logic                                             rst_n_i,
    // active coefficients, row major
    input  logic [ccm_pkg::COE_COUNT*ccm_pkg::COE_WIDTH-1:0] coe_i,
    input  logic                                             en_i,
    // video in
    input  logic [3*PIXEL_WIDTH-1:0]                         pix_i,
    input  logic                                             de_i,
    input  logic                                             hs_i,
    input  logic                                             vs_i,
    // video out
    output logic [3*PIXEL_WIDTH-1:0]                         pix_o,
    output logic                                             de_o,
    output logic                                             hs_o,
    output logic                                             vs_o
);
    import ccm_pkg::*;

    // must match the channel unit pipeline
    localparam int PIPE_DEPTH = 5;

    coe_t                     coe [COE_COUNT];
    logic [PIXEL_WIDTH-1:0]   chan [3];
    logic [3*PIXEL_WIDTH-1:0] pix_dly [PIPE_DEPTH];
    logic [PIPE_DEPTH-1:0]    de_dly;
    logic [PIPE_DEPTH-1:0]    hs_dly;
    logic [PIPE_DEPTH-1:0]    vs_dly;

    always_comb begin
        for (int k = 0; k < COE_COUNT; k++) begin
            coe[k] = coe_i[k*COE_WIDTH +: COE_WIDTH];
        end
    end

    // ------------------------------
    // channel units, one per row
    // ------------------------------

    for (genvar c = 0; c < 3; c++) begin : g_chan
        ccm_channel_mac #(
            .PIXEL_WIDTH (PIXEL_WIDTH)
        ) u_mac (
            .clk     (clk),
            .coe_r_i (coe[3*c + 0]),
            .coe_g_i (coe[3*c + 1]),
            .coe_b_i (coe[3*c + 2]),
            .pix_i   (pix_i),
            .chan_o  (chan[c])
        );
    end

    // ------------------------------
    // delay lines
    // ------------------------------

    // sync signals, cleared so no false frame after reset
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            de_dly <= '0;
            hs_dly <= '0;
            vs_dly <= '0;
        end else begin
            de_dly <= {de_dly[PIPE_DEPTH-2:0], de_i};
            hs_dly <= {hs_dly[PIPE_DEPTH-2:0], hs_i};
            vs_dly <= {vs_dly[PIPE_DEPTH-2:0], vs_i};
        end
    end

    // raw pixel for bypass
    always_ff @(posedge clk) begin
        pix_dly[0] <= pix_i;
        for (int s = 1; s < PIPE_DEPTH; s++) begin
            pix_dly[s] <= pix_dly[s-1];
        end
    end

    // processed or raw, per channel
    always_comb begin
        for (int c = 0; c < 3; c++) begin
            pix_o[c*PIXEL_WIDTH +: PIXEL_WIDTH] =
                en_i ? chan[c] : pix_dly[PIPE_DEPTH-1][c*PIXEL_WIDTH +: PIXEL_WIDTH];
        end
    end

    assign de_o = de_dly[PIPE_DEPTH-1];
    assign hs_o = hs_dly[PIPE_DEPTH-1];
    assign vs_o = vs_dly[PIPE_DEPTH-1];

endmodule

// File: source/ccm_top.sv
`timescale 1ns/1ps
// ------------------------------
// ccm colour correction top level
// register bank and matrix datapath
// ------------------------------
module ccm_top #(
    parameter int PIXEL_WIDTH = 8
) (
    input  logic                     clk,
    input  logic                     rst_n_i,
    // Wishbone classic slave
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  ccm_pkg::wb_adr_t         wb_adr_i,
    input  ccm_pkg::wb_dat_t         wb_dat_i,
    output ccm_pkg::wb_dat_t         wb_dat_o,
    output logic                     wb_ack_o,
    // video in
    input  logic [3*PIXEL_WIDTH-1:0] pix_i,
    input  logic                     de_i,
    input  logic                     hs_i,
    input  logic                     vs_i,
    // video out, five clocks later
    output logic [3*PIXEL_WIDTH-1:0] pix_o,
    output logic                     de_o,
    output logic                     hs_o,
    output logic                     vs_o
);
    import ccm_pkg::*;

    logic [COE_COUNT*COE_WIDTH-1:0] coe_act;
    logic                           en_act;

    // register bank, also sees vs for the frame-start swap
    ccm_wb_regs u_regs (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .vs_i     (vs_i),
        .coe_o    (coe_act),
        .en_o     (en_act)
    );

    // datapath
    ccm_matrix #(
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) u_matrix (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .coe_i   (coe_act),
        .en_i    (en_act),
        .pix_i   (pix_i),
        .de_i    (de_i),
        .hs_i    (hs_i),
        .vs_i    (vs_i),
        .pix_o   (pix_o),
        .de_o    (de_o),
        .hs_o    (hs_o),
        .vs_o    (vs_o)
    );

endmodule

// File: dv/ccm_tb.sv
`timescale 1ns/1ps
// ------------------------------
// ccm testbench
// replays bus and pixel records from a data file
// and checks pixel, sync and bus responses
// ------------------------------
module ccm_tb;
    import ccm_pkg::*;

    localparam int PIXEL_WIDTH   = 8;
    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 10;
    localparam int SYNC_LAT      = 5;
    localparam int BUS_TIMEOUT   = 20;
    localparam int DRAIN_TIMEOUT = 200;

    logic                     clk;
    logic                     rst_n_i;
    logic                     wb_cyc_i;
    logic                     wb_stb_i;
    logic                     wb_we_i;
    wb_adr_t                  wb_adr_i;
    wb_dat_t                  wb_dat_i;
    wb_dat_t                  wb_dat_o;
    logic                     wb_ack_o;
    logic [3*PIXEL_WIDTH-1:0] pix_i;
    logic                     de_i;
    logic                     hs_i;
    logic                     vs_i;
    logic [3*PIXEL_WIDTH-1:0] pix_o;
    logic                     de_o;
    logic                     hs_o;
    logic                     vs_o;

    // expected pixels in output order with the test that queued them
    logic [3*PIXEL_WIDTH-1:0] exp_q [$];
    string                    name_q [$];
    string                    cur_test;
    // input syncs {de, hs, vs} with the newest in slot 0
    logic [2:0]               sync_hist [SYNC_LAT];

    ccm_top #(
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) dut0 (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .pix_i    (pix_i),
        .de_i     (de_i),
        .hs_i     (hs_i),
        .vs_i     (vs_i),
        .pix_o    (pix_o),
        .de_o     (de_o),
        .hs_o     (hs_o),
        .vs_o     (vs_o)
    );

    // ------------------------------
    // helpers
    // ------------------------------

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else
            abort_run($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
                                test, expected, actual));
    endtask

    task automatic read_pair(input int fd, output logic [31:0] a, output logic [31:0] b);
        int n;
        n = $fscanf(fd, "%h %h", a, b);
        assert (n == 2) else abort_run("malformed record in the stimulus file");
    endtask

    // one classic cycle with the ack expected one clock after the request
    task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                              output wb_dat_t rdat);
        int waited;
        @(posedge clk);
        #1;
        de_i     = 1'b0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        waited   = 0;
        @(negedge clk);
        while (wb_ack_o !== 1'b1 && waited < BUS_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        assert (wb_ack_o === 1'b1) else abort_run("bus timeout, no acknowledge");
        check_value({cur_test, " ack latency"}, 1, waited);
        rdat = wb_dat_o;
        @(posedge clk);
        #1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(negedge clk);
        check_value({cur_test, " ack width"}, 0, wb_ack_o);
        // idle gap between bus cycles
        repeat ($urandom_range(3, 0)) @(posedge clk);
    endtask

    task automatic send_pixel(input logic [23:0] pix, input logic [23:0] expected);
        @(posedge clk);
        #1;
        pix_i = pix;
        de_i  = 1'b1;
        exp_q.push_back(expected);
        name_q.push_back(cur_test);
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        assert (exp_q.size() == 0) else abort_run("output timeout, pixels missing");
    endtask

    // blanking before and after a two-cycle vs pulse
    // hs is high only in the first cycle of the pulse
    task automatic frame_start();
        @(posedge clk);
        #1;
        de_i = 1'b0;
        drain_outputs();
        repeat ($urandom_range(9, 5)) @(posedge clk);
        #1;
        vs_i = 1'b1;
        hs_i = 1'b1;
        @(posedge clk);
        #1;
        hs_i = 1'b0;
        @(posedge clk);
        #1;
        vs_i = 1'b0;
        repeat ($urandom_range(9, 5)) @(posedge clk);
    endtask

    // ------------------------------
    // clock and output monitor
    // ------------------------------

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        if (rst_n_i) begin
            check_value("sync delay", sync_hist[SYNC_LAT-1], {de_o, hs_o, vs_o});
            if (de_o === 1'b1) begin
                assert (exp_q.size() != 0) else abort_run("pixel on the output with none expected");
                check_value(name_q.pop_front(), exp_q.pop_front(), pix_o);
            end
        end
        for (int k = SYNC_LAT - 1; k > 0; k--) begin
            sync_hist[k] = sync_hist[k-1];
        end
        sync_hist[0] = {de_i, hs_i, vs_i};
    end

    // ------------------------------
    // record player
    // ------------------------------

    initial begin
        int          fd;
        string       cmd;
        string       line;
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        wb_dat_t     rdat;
        void'($urandom(32'h7021));
        rst_n_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        pix_i    = '0;
        de_i     = 1'b0;
        hs_i     = 1'b0;
        vs_i     = 1'b0;
        cur_test = "reset";
        for (int k = 0; k < SYNC_LAT; k++) begin
            sync_hist[k] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        fd = $fopen("dv/ccm_input.txt", "r");
        assert (fd != 0) else abort_run("cannot open dv/ccm_input.txt");
        while ($fscanf(fd, "%s", cmd) == 1) begin
            case (cmd)
                "#": void'($fgets(line, fd));
                "T": void'($fscanf(fd, "%s", cur_test));
                "F": frame_start();
                "W": begin
                    read_pair(fd, arg_a, arg_b);
                    bus_access(1'b1, arg_a[3:0], arg_b[15:0], rdat);
                end
                "R": begin
                    read_pair(fd, arg_a, arg_b);
                    bus_access(1'b0, arg_a[3:0], '0, rdat);
                    check_value(cur_test, arg_b, rdat);
                end
                "P": begin
                    read_pair(fd, arg_a, arg_b);
                    send_pixel(arg_a[23:0], arg_b[23:0]);
                end
                default: abort_run({"unknown record kind in the stimulus file: ", cmd});
            endcase
        end
        $fclose(fd);
        @(posedge clk);
        #1;
        de_i = 1'b0;
        drain_outputs();
        $display("all tests passed");
        $finish;
    end

endmodule

// File: ccm.f
source/ccm_pkg.sv
source/ccm_wb_regs.sv
source/ccm_channel_mac.sv
source/ccm_matrix.sv
source/ccm_top.sv
dv/ccm_tb.sv

// File: dv/ccm_input.txt
# records: T name | W adr data | R adr expected | F frame start | P pixel expected
# all values hex, pixels packed blue, green, red from high to low byte
T reg_reset
R 0 0400
R 1 0000
R 8 0400
R 9 0000
T reg_access
W 0 1234
W 5 abcd
W 9 ffff
W c 5555
R 0 1234
R 5 abcd
R 9 0001
R c 0000
R f 0000
W 0 0400
W 5 0000
W 9 0000
T bypass
P 000000 000000
P ffffff ffffff
P 5a3c1e 5a3c1e
T identity
W 9 0001
F
P 123456 123456
P ff00ff ff00ff
T general
W 0 0500
W 1 ff00
W 3 0080
W 4 0380
W 6 ffc0
W 8 0440
F
P 103264 0b3871
P 21070b 22080c
P 80ffc8 7cf8ba
P 000a03 000901
T saturation
W 0 0800
W 1 0000
W 3 0000
W 4 fc00
W 6 0000
W 8 0400
F
P 552090 5500ff
P ff007f ff00fe
P 000180 0000ff
# identity staged mid-frame, old matrix until vs
T frame_update
W 0 0400
W 4 0400
P 552090 5500ff
F
P 552090 552090
W 9 0000
W 0 0800
P 123456 123456
F
P 123456 123456
